// ==== build.f ====
+incdir+design
design/core_pkg.sv
design/core_ctrl.sv
design/tag_counter.sv
design/dispatch_simple.sv
design/integer_issue.sv
design/integer_execute.sv
design/core.sv
sim/core_tb.sv

// ==== design/core.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         init,
    input  logic [`REG_DATA_WIDTH-1:0]                   init_sp,
    input  logic                                         instr_valid,
    input  core_pkg::alu_op_t                            instr_op,
    input  logic [`ARF_IDX_WIDTH-1:0]                    instr_rd,
    input  logic [`ARF_IDX_WIDTH-1:0]                    instr_rs1,
    input  logic [`ARF_IDX_WIDTH-1:0]                    instr_rs2,
    input  logic [`REG_DATA_WIDTH-1:0]                   instr_imm,
    output logic                                         instr_ready,
    output logic                                         result_valid,
    output logic [`ROB_ID_WIDTH-1:0]                     result_rob_id,
    output logic [`REG_DATA_WIDTH-1:0]                   result_data,
    output logic                                         idle,
    output logic [`ARF_N_ENTRIES-1:0][`REG_DATA_WIDTH-1:0] arf_out
);

    // controller
    logic                       clear_active, run, in_flight_zero;
    logic [`ARF_IDX_WIDTH-1:0]  clear_index;
    // rob id allocation
    logic                       alloc, tag_full;
    logic [`ROB_ID_WIDTH-1:0]   next_rob_id;
    // dispatch to issue queue
    logic                       iiq_dispatch_valid, iiq_dispatch_ready;
    core_pkg::alu_op_t          iiq_dispatch_op;
    logic [`ROB_ID_WIDTH-1:0]   iiq_dispatch_rob_id, iiq_dispatch_src1_tag, iiq_dispatch_src2_tag;
    logic [`ARF_IDX_WIDTH-1:0]  iiq_dispatch_rd;
    logic [`REG_DATA_WIDTH-1:0] iiq_dispatch_imm, iiq_dispatch_src1_value, iiq_dispatch_src2_value;
    logic                       iiq_dispatch_src1_ready, iiq_dispatch_src2_ready;
    // issue to alu
    logic                       issue_valid;
    core_pkg::alu_op_t          issue_op;
    logic [`ROB_ID_WIDTH-1:0]   issue_rob_id;
    logic [`ARF_IDX_WIDTH-1:0]  issue_rd;
    logic [`REG_DATA_WIDTH-1:0] issue_imm, issue_src1, issue_src2;
    // alu broadcast to queue, dispatch and tag counter
    logic                       alu_broadcast_valid;
    logic [`ROB_ID_WIDTH-1:0]   alu_broadcast_rob_id;
    logic [`ARF_IDX_WIDTH-1:0]  alu_broadcast_rd;
    logic [`REG_DATA_WIDTH-1:0] alu_broadcast_data;

    core_ctrl i_core_ctrl (
        .clk(clk), .rst_n(rst_n), .init(init), .in_flight_zero(in_flight_zero),
        .clear_active(clear_active), .run(run), .idle(idle), .clear_index(clear_index)
    );

    tag_counter i_tag_counter (
        .clk(clk), .rst_n(rst_n), .run(run), .alloc(alloc),
        .release_en(alu_broadcast_valid), .next_rob_id(next_rob_id),
        .full(tag_full), .in_flight_zero(in_flight_zero)
    );

    dispatch_simple i_dispatch (
        .clk(clk), .rst_n(rst_n), .run(run),
        .clear_active(clear_active), .clear_index(clear_index), .init_sp(init_sp),
        .instr_valid(instr_valid), .instr_op(instr_op), .instr_rd(instr_rd),
        .instr_rs1(instr_rs1), .instr_rs2(instr_rs2), .instr_imm(instr_imm),
        .instr_ready(instr_ready),
        .tag_full(tag_full), .next_rob_id(next_rob_id), .alloc(alloc),
        .iiq_dispatch_ready(iiq_dispatch_ready), .iiq_dispatch_valid(iiq_dispatch_valid),
        .iiq_dispatch_op(iiq_dispatch_op), .iiq_dispatch_rob_id(iiq_dispatch_rob_id),
        .iiq_dispatch_rd(iiq_dispatch_rd), .iiq_dispatch_imm(iiq_dispatch_imm),
        .iiq_dispatch_src1_ready(iiq_dispatch_src1_ready),
        .iiq_dispatch_src1_value(iiq_dispatch_src1_value),
        .iiq_dispatch_src1_tag(iiq_dispatch_src1_tag),
        .iiq_dispatch_src2_ready(iiq_dispatch_src2_ready),
        .iiq_dispatch_src2_value(iiq_dispatch_src2_value),
        .iiq_dispatch_src2_tag(iiq_dispatch_src2_tag),
        .alu_broadcast_valid(alu_broadcast_valid), .alu_broadcast_rob_id(alu_broadcast_rob_id),
        .alu_broadcast_rd(alu_broadcast_rd), .alu_broadcast_data(alu_broadcast_data),
        .arf_out(arf_out)
    );

    integer_issue i_integer_issue (
        .clk(clk), .rst_n(rst_n),
        .dispatch_ready(iiq_dispatch_ready), .dispatch_valid(iiq_dispatch_valid),
        .dispatch_op(iiq_dispatch_op), .dispatch_rob_id(iiq_dispatch_rob_id),
        .dispatch_rd(iiq_dispatch_rd), .dispatch_imm(iiq_dispatch_imm),
        .dispatch_src1_ready(iiq_dispatch_src1_ready),
        .dispatch_src1_value(iiq_dispatch_src1_value),
        .dispatch_src1_tag(iiq_dispatch_src1_tag),
        .dispatch_src2_ready(iiq_dispatch_src2_ready),
        .dispatch_src2_value(iiq_dispatch_src2_value),
        .dispatch_src2_tag(iiq_dispatch_src2_tag),
        .alu_broadcast_valid(alu_broadcast_valid), .alu_broadcast_rob_id(alu_broadcast_rob_id),
        .alu_broadcast_data(alu_broadcast_data),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rob_id(issue_rob_id),
        .issue_rd(issue_rd), .issue_imm(issue_imm),
        .issue_src1(issue_src1), .issue_src2(issue_src2)
    );

    // alu is always ready
    integer_execute i_integer_execute (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rob_id(issue_rob_id),
        .issue_rd(issue_rd), .issue_imm(issue_imm),
        .issue_src1(issue_src1), .issue_src2(issue_src2),
        .alu_broadcast_valid(alu_broadcast_valid), .alu_broadcast_rob_id(alu_broadcast_rob_id),
        .alu_broadcast_rd(alu_broadcast_rd), .alu_broadcast_data(alu_broadcast_data)
    );

    // results leave the slice as the broadcast
    assign result_valid  = alu_broadcast_valid;
    assign result_rob_id = alu_broadcast_rob_id;
    assign result_data   = alu_broadcast_data;

endmodule

// ==== design/core_ctrl.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init,
    input  logic                      in_flight_zero,
    output logic                      clear_active,
    output logic                      run,
    output logic                      idle,
    output logic [`ARF_IDX_WIDTH-1:0] clear_index
);

    core_pkg::ctrl_state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= core_pkg::CTRL_IDLE;
            clear_index <= '0;
        end else if (init) begin
            // init restarts the walk from register 0
            state       <= core_pkg::CTRL_CLEAR;
            clear_index <= '0;
        end else if (state == core_pkg::CTRL_CLEAR) begin
            // one register per cycle
            clear_index <= clear_index + 1'b1;
            // last register written this cycle, index wraps back to 0
            if (clear_index == `ARF_IDX_WIDTH'(`ARF_N_ENTRIES - 1)) begin
                state <= core_pkg::CTRL_RUN;
            end
        end
    end

    assign clear_active = (state == core_pkg::CTRL_CLEAR);
    assign run          = (state == core_pkg::CTRL_RUN);
    // nothing between dispatch and broadcast
    assign idle         = run && in_flight_zero;

    // re-init only once the slice has drained
    a_init_drained: assert property (
        @(posedge clk) disable iff (!rst_n)
        (init && run) |-> in_flight_zero
    ) else $error("init while instructions in flight");

endmodule

// ==== design/core_pkg.sv ====
package core_pkg;

    // integer alu opcodes
    // addi takes the immediate in place of the second source
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SLT,
        ALU_ADDI
    } alu_op_t;

    // init and run controller
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_CLEAR,
        CTRL_RUN
    } ctrl_state_t;

endpackage

// ==== design/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// architectural register file, register 0 reads zero
`define ARF_N_ENTRIES 8
`define ARF_IDX_WIDTH 3
`define REG_DATA_WIDTH 16

// rob id width, 2**width tags in flight
`define ROB_ID_WIDTH 3

// integer issue queue entries
`define IIQ_DEPTH 4

// register loaded with init_sp during clear
`define SP_INDEX 2

`endif

// ==== design/dispatch_simple.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module dispatch_simple (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         run,
    input  logic                                         clear_active,
    input  logic [`ARF_IDX_WIDTH-1:0]                    clear_index,
    input  logic [`REG_DATA_WIDTH-1:0]                   init_sp,
    input  logic                                         instr_valid,
    input  core_pkg::alu_op_t                            instr_op,
    input  logic [`ARF_IDX_WIDTH-1:0]                    instr_rd,
    input  logic [`ARF_IDX_WIDTH-1:0]                    instr_rs1,
    input  logic [`ARF_IDX_WIDTH-1:0]                    instr_rs2,
    input  logic [`REG_DATA_WIDTH-1:0]                   instr_imm,
    output logic                                         instr_ready,
    input  logic                                         tag_full,
    input  logic [`ROB_ID_WIDTH-1:0]                     next_rob_id,
    output logic                                         alloc,
    input  logic                                         iiq_dispatch_ready,
    output logic                                         iiq_dispatch_valid,
    output core_pkg::alu_op_t                            iiq_dispatch_op,
    output logic [`ROB_ID_WIDTH-1:0]                     iiq_dispatch_rob_id,
    output logic [`ARF_IDX_WIDTH-1:0]                    iiq_dispatch_rd,
    output logic [`REG_DATA_WIDTH-1:0]                   iiq_dispatch_imm,
    output logic                                         iiq_dispatch_src1_ready,
    output logic [`REG_DATA_WIDTH-1:0]                   iiq_dispatch_src1_value,
    output logic [`ROB_ID_WIDTH-1:0]                     iiq_dispatch_src1_tag,
    output logic                                         iiq_dispatch_src2_ready,
    output logic [`REG_DATA_WIDTH-1:0]                   iiq_dispatch_src2_value,
    output logic [`ROB_ID_WIDTH-1:0]                     iiq_dispatch_src2_tag,
    input  logic                                         alu_broadcast_valid,
    input  logic [`ROB_ID_WIDTH-1:0]                     alu_broadcast_rob_id,
    input  logic [`ARF_IDX_WIDTH-1:0]                    alu_broadcast_rd,
    input  logic [`REG_DATA_WIDTH-1:0]                   alu_broadcast_data,
    output logic [`ARF_N_ENTRIES-1:0][`REG_DATA_WIDTH-1:0] arf_out
);

    logic [`ARF_N_ENTRIES-1:0][`REG_DATA_WIDTH-1:0] arf;
    // scoreboard, newest producer per register
    logic [`ARF_N_ENTRIES-1:0] busy;
    logic [`ROB_ID_WIDTH-1:0]  tag [`ARF_N_ENTRIES];
    logic                      accept;
    logic                      wb_hit;

    // {ready, value} for one source
    function automatic logic [`REG_DATA_WIDTH:0] read_src(input logic [`ARF_IDX_WIDTH-1:0] rs);
        if (rs == '0)
            return '1 << `REG_DATA_WIDTH;
        if (!busy[rs])
            return {1'b1, arf[rs]};
        // producer on the broadcast this cycle
        if (alu_broadcast_valid && alu_broadcast_rob_id == tag[rs])
            return {1'b1, alu_broadcast_data};
        return {1'b0, arf[rs]};
    endfunction

    assign instr_ready = run && !tag_full && iiq_dispatch_ready;
    assign accept      = instr_valid && instr_ready;
    assign alloc       = accept;
    // stale broadcasts leave a newer producer's register alone
    assign wb_hit = alu_broadcast_valid && busy[alu_broadcast_rd]
                    && (tag[alu_broadcast_rd] == alu_broadcast_rob_id);

    always_comb begin
        iiq_dispatch_valid  = accept;
        iiq_dispatch_op     = instr_op;
        iiq_dispatch_rob_id = next_rob_id;
        iiq_dispatch_rd     = instr_rd;
        iiq_dispatch_imm    = instr_imm;
        {iiq_dispatch_src1_ready, iiq_dispatch_src1_value} = read_src(instr_rs1);
        {iiq_dispatch_src2_ready, iiq_dispatch_src2_value} = read_src(instr_rs2);
        iiq_dispatch_src1_tag = tag[instr_rs1];
        iiq_dispatch_src2_tag = tag[instr_rs2];
        // addi never waits on rs2
        if (instr_op == core_pkg::ALU_ADDI)
            iiq_dispatch_src2_ready = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear_active) begin
            busy <= '0;
        end else begin
            if (wb_hit)
                busy[alu_broadcast_rd] <= 1'b0;
            // new producer wins over a same-cycle writeback
            if (accept && instr_rd != '0)
                busy[instr_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clear_active)
            arf[clear_index] <= (clear_index == `ARF_IDX_WIDTH'(`SP_INDEX)) ? init_sp : '0;
        else if (wb_hit)
            arf[alu_broadcast_rd] <= alu_broadcast_data;
        if (accept)
            tag[instr_rd] <= next_rob_id;
    end

    assign arf_out = arf;

endmodule

// ==== design/integer_execute.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module integer_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue_valid,
    input  core_pkg::alu_op_t          issue_op,
    input  logic [`ROB_ID_WIDTH-1:0]   issue_rob_id,
    input  logic [`ARF_IDX_WIDTH-1:0]  issue_rd,
    input  logic [`REG_DATA_WIDTH-1:0] issue_imm,
    input  logic [`REG_DATA_WIDTH-1:0] issue_src1,
    input  logic [`REG_DATA_WIDTH-1:0] issue_src2,
    output logic                       alu_broadcast_valid,
    output logic [`ROB_ID_WIDTH-1:0]   alu_broadcast_rob_id,
    output logic [`ARF_IDX_WIDTH-1:0]  alu_broadcast_rd,
    output logic [`REG_DATA_WIDTH-1:0] alu_broadcast_data
);

    localparam int SHAMT_W = $clog2(`REG_DATA_WIDTH);

    logic [`REG_DATA_WIDTH-1:0] opb;
    logic [`REG_DATA_WIDTH-1:0] result;

    always_comb begin
        // immediate replaces rs2 for addi
        opb = (issue_op == core_pkg::ALU_ADDI) ? issue_imm : issue_src2;
        case (issue_op)
            core_pkg::ALU_ADD, core_pkg::ALU_ADDI: result = issue_src1 + opb;
            core_pkg::ALU_SUB: result = issue_src1 - opb;
            core_pkg::ALU_AND: result = issue_src1 & opb;
            core_pkg::ALU_OR:  result = issue_src1 | opb;
            core_pkg::ALU_XOR: result = issue_src1 ^ opb;
            // low bits only as shift amount
            core_pkg::ALU_SLL: result = issue_src1 << opb[SHAMT_W-1:0];
            core_pkg::ALU_SLT: result = `REG_DATA_WIDTH'($signed(issue_src1) < $signed(opb));
            default:           result = '0;
        endcase
    end

    // broadcast one cycle after issue
    always_ff @(posedge clk) begin
        if (!rst_n)
            alu_broadcast_valid <= 1'b0;
        else
            alu_broadcast_valid <= issue_valid;
        alu_broadcast_rob_id <= issue_rob_id;
        alu_broadcast_rd     <= issue_rd;
        alu_broadcast_data   <= result;
    end

endmodule

// ==== design/integer_issue.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module integer_issue (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic                       dispatch_ready,
    input  logic                       dispatch_valid,
    input  core_pkg::alu_op_t          dispatch_op,
    input  logic [`ROB_ID_WIDTH-1:0]   dispatch_rob_id,
    input  logic [`ARF_IDX_WIDTH-1:0]  dispatch_rd,
    input  logic [`REG_DATA_WIDTH-1:0] dispatch_imm,
    input  logic                       dispatch_src1_ready,
    input  logic [`REG_DATA_WIDTH-1:0] dispatch_src1_value,
    input  logic [`ROB_ID_WIDTH-1:0]   dispatch_src1_tag,
    input  logic                       dispatch_src2_ready,
    input  logic [`REG_DATA_WIDTH-1:0] dispatch_src2_value,
    input  logic [`ROB_ID_WIDTH-1:0]   dispatch_src2_tag,
    input  logic                       alu_broadcast_valid,
    input  logic [`ROB_ID_WIDTH-1:0]   alu_broadcast_rob_id,
    input  logic [`REG_DATA_WIDTH-1:0] alu_broadcast_data,
    output logic                       issue_valid,
    output core_pkg::alu_op_t          issue_op,
    output logic [`ROB_ID_WIDTH-1:0]   issue_rob_id,
    output logic [`ARF_IDX_WIDTH-1:0]  issue_rd,
    output logic [`REG_DATA_WIDTH-1:0] issue_imm,
    output logic [`REG_DATA_WIDTH-1:0] issue_src1,
    output logic [`REG_DATA_WIDTH-1:0] issue_src2
);

    localparam int IDX_W = $clog2(`IIQ_DEPTH);
    // wide enough that ages never alias while an entry waits
    localparam int SEQ_W = IDX_W + 2;

    logic [`IIQ_DEPTH-1:0]      valid, rdy1, rdy2, hit1, hit2, can_issue;
    core_pkg::alu_op_t          op     [`IIQ_DEPTH];
    logic [`ROB_ID_WIDTH-1:0]   rob_id [`IIQ_DEPTH];
    logic [`ROB_ID_WIDTH-1:0]   tag1   [`IIQ_DEPTH];
    logic [`ROB_ID_WIDTH-1:0]   tag2   [`IIQ_DEPTH];
    logic [`ARF_IDX_WIDTH-1:0]  rd     [`IIQ_DEPTH];
    logic [`REG_DATA_WIDTH-1:0] imm    [`IIQ_DEPTH];
    logic [`REG_DATA_WIDTH-1:0] val1   [`IIQ_DEPTH];
    logic [`REG_DATA_WIDTH-1:0] val2   [`IIQ_DEPTH];
    logic [SEQ_W-1:0]           seq    [`IIQ_DEPTH];
    logic [SEQ_W-1:0]           age    [`IIQ_DEPTH];
    logic [SEQ_W-1:0]           seq_cnt, best_age;
    logic [IDX_W-1:0]           sel, wr_sel;
    logic                       free_found;

    // wakeup match and age per entry
    always_comb begin
        for (int i = 0; i < `IIQ_DEPTH; i++) begin
            hit1[i] = alu_broadcast_valid && !rdy1[i] && (tag1[i] == alu_broadcast_rob_id);
            hit2[i] = alu_broadcast_valid && !rdy2[i] && (tag2[i] == alu_broadcast_rob_id);
            can_issue[i] = valid[i] && (rdy1[i] || hit1[i]) && (rdy2[i] || hit2[i]);
            age[i] = seq_cnt - seq[i];
        end
    end

    // oldest ready, then first free slot
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        best_age    = '0;
        free_found  = 1'b0;
        wr_sel      = '0;
        for (int i = 0; i < `IIQ_DEPTH; i++) begin
            if (can_issue[i] && (!issue_valid || age[i] > best_age)) begin
                issue_valid = 1'b1;
                sel         = IDX_W'(i);
                best_age    = age[i];
            end
        end
        for (int i = 0; i < `IIQ_DEPTH; i++) begin
            if (!valid[i] && !free_found) begin
                free_found = 1'b1;
                wr_sel     = IDX_W'(i);
            end
        end
        // no free slot, reuse the one issuing now
        if (!free_found)
            wr_sel = sel;
    end

    assign dispatch_ready = free_found || issue_valid;
    assign issue_op       = op[sel];
    assign issue_rob_id   = rob_id[sel];
    assign issue_rd       = rd[sel];
    assign issue_imm      = imm[sel];
    // bypass straight from the broadcast
    assign issue_src1     = rdy1[sel] ? val1[sel] : alu_broadcast_data;
    assign issue_src2     = rdy2[sel] ? val2[sel] : alu_broadcast_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid   <= '0;
            seq_cnt <= '0;
        end else begin
            for (int i = 0; i < `IIQ_DEPTH; i++) begin
                if (hit1[i]) begin
                    rdy1[i] <= 1'b1;
                    val1[i] <= alu_broadcast_data;
                end
                if (hit2[i]) begin
                    rdy2[i] <= 1'b1;
                    val2[i] <= alu_broadcast_data;
                end
            end
            if (issue_valid)
                valid[sel] <= 1'b0;
            // write after free so a reused slot stays valid
            if (dispatch_valid) begin
                valid[wr_sel]  <= 1'b1;
                op[wr_sel]     <= dispatch_op;
                rob_id[wr_sel] <= dispatch_rob_id;
                rd[wr_sel]     <= dispatch_rd;
                imm[wr_sel]    <= dispatch_imm;
                rdy1[wr_sel]   <= dispatch_src1_ready;
                val1[wr_sel]   <= dispatch_src1_value;
                tag1[wr_sel]   <= dispatch_src1_tag;
                rdy2[wr_sel]   <= dispatch_src2_ready;
                val2[wr_sel]   <= dispatch_src2_value;
                tag2[wr_sel]   <= dispatch_src2_tag;
                seq[wr_sel]    <= seq_cnt;
                seq_cnt        <= seq_cnt + 1'b1;
            end
        end
    end

    // dispatch lands in a free slot or in the one issuing now
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (!rst_n)
        dispatch_valid |-> !valid[wr_sel] || (issue_valid && wr_sel == sel)
    ) else $error("dispatch overwrote an entry still waiting to issue");

endmodule

// ==== design/tag_counter.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module tag_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     alloc,
    input  logic                     release_en,
    output logic [`ROB_ID_WIDTH-1:0] next_rob_id,
    output logic                     full,
    output logic                     in_flight_zero
);

    // one extra bit so a full set of tags is countable
    logic [`ROB_ID_WIDTH:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_rob_id <= '0;
            count       <= '0;
        end else begin
            // ids restart at 0 for each run
            if (!run) begin
                next_rob_id <= '0;
            end else if (alloc) begin
                next_rob_id <= next_rob_id + 1'b1;
            end
            // alloc and release together leave the count alone
            case ({alloc, release_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // msb set only at the full tag count
    assign full           = count[`ROB_ID_WIDTH];
    assign in_flight_zero = (count == '0);

    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst_n) alloc |-> !full
    ) else $error("rob id allocated while all tags in flight");

    a_no_release_empty: assert property (
        @(posedge clk) disable iff (!rst_n) release_en |-> !in_flight_zero
    ) else $error("broadcast with no instruction in flight");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module core_tb -o core_tb_sim
./obj_dir/core_tb_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;

    localparam int PROGRAM_LEN = 300;
    localparam int N_PROGRAMS  = 2;
    localparam int N_TAGS      = 1 << `ROB_ID_WIDTH;
    // 20 cycles per instruction, plus reset, the pre-init window and each clear walk
    localparam int WATCHDOG_CYCLES =
        16 + 20 + N_PROGRAMS * (PROGRAM_LEN * 20 + `ARF_N_ENTRIES + 4);

    logic                                           clk;
    logic                                           rst_n;
    logic                                           init;
    logic [`REG_DATA_WIDTH-1:0]                     init_sp;
    logic                                           instr_valid;
    core_pkg::alu_op_t                              instr_op;
    logic [`ARF_IDX_WIDTH-1:0]                      instr_rd;
    logic [`ARF_IDX_WIDTH-1:0]                      instr_rs1;
    logic [`ARF_IDX_WIDTH-1:0]                      instr_rs2;
    logic [`REG_DATA_WIDTH-1:0]                     instr_imm;
    logic                                           instr_ready;
    logic                                           result_valid;
    logic [`ROB_ID_WIDTH-1:0]                       result_rob_id;
    logic [`REG_DATA_WIDTH-1:0]                     result_data;
    logic                                           idle;
    logic [`ARF_N_ENTRIES-1:0][`REG_DATA_WIDTH-1:0] arf_out;

    // reference model, program order
    logic [`REG_DATA_WIDTH-1:0] model_arf [`ARF_N_ENTRIES];
    logic [`REG_DATA_WIDTH-1:0] expected  [N_TAGS];
    bit                         pending   [N_TAGS];
    logic [`ROB_ID_WIDTH-1:0]   model_rob;
    int                         accepted;
    int                         results;
    // handshake seen at the last falling edge
    bit                         taken;
    bit                         pre_init;

    core i_core (
        .clk(clk), .rst_n(rst_n), .init(init), .init_sp(init_sp),
        .instr_valid(instr_valid), .instr_op(instr_op), .instr_rd(instr_rd),
        .instr_rs1(instr_rs1), .instr_rs2(instr_rs2), .instr_imm(instr_imm),
        .instr_ready(instr_ready), .result_valid(result_valid),
        .result_rob_id(result_rob_id), .result_data(result_data),
        .idle(idle), .arf_out(arf_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAILED at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // alu behaviour, shift amount taken modulo the data width
    function automatic logic [`REG_DATA_WIDTH-1:0] alu_model(
        input core_pkg::alu_op_t op, input logic [`REG_DATA_WIDTH-1:0] a,
        input logic [`REG_DATA_WIDTH-1:0] b, input logic [`REG_DATA_WIDTH-1:0] imm);
        case (op)
            core_pkg::ALU_ADD:  return a + b;
            core_pkg::ALU_SUB:  return a - b;
            core_pkg::ALU_AND:  return a & b;
            core_pkg::ALU_OR:   return a | b;
            core_pkg::ALU_XOR:  return a ^ b;
            core_pkg::ALU_SLL:  return a << (b % `REG_DATA_WIDTH);
            core_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            core_pkg::ALU_ADDI: return a + imm;
            default:            return '0;
        endcase
    endfunction

    task automatic new_random_instr();
        instr_op  = core_pkg::alu_op_t'($urandom_range(0, 7));
        instr_rd  = `ARF_IDX_WIDTH'($urandom_range(0, `ARF_N_ENTRIES - 1));
        instr_rs1 = `ARF_IDX_WIDTH'($urandom_range(0, `ARF_N_ENTRIES - 1));
        instr_rs2 = `ARF_IDX_WIDTH'($urandom_range(0, `ARF_N_ENTRIES - 1));
        instr_imm = `REG_DATA_WIDTH'($urandom);
    endtask

    task automatic check_result();
        assert (pending[result_rob_id])
            else report_failure($sformatf("result for rob id %0d, none outstanding",
                                          result_rob_id));
        assert (result_data == expected[result_rob_id])
            else report_mismatch("result_data", expected[result_rob_id], result_data);
        pending[result_rob_id] = 1'b0;
        results++;
    endtask

    task automatic record_instr();
        logic [`REG_DATA_WIDTH-1:0] res;
        // model_arf[0] is never written and stays zero
        res = alu_model(instr_op, model_arf[instr_rs1], model_arf[instr_rs2], instr_imm);
        assert (!pending[model_rob])
            else report_failure("rob id handed out again while still outstanding");
        expected[model_rob] = res;
        pending[model_rob]  = 1'b1;
        if (instr_rd != '0)
            model_arf[instr_rd] = res;
        model_rob = model_rob + 1'b1;
        accepted++;
    endtask

    task automatic check_arf();
        for (int i = 0; i < `ARF_N_ENTRIES; i++) begin
            assert (arf_out[i] == model_arf[i])
                else report_mismatch($sformatf("arf_out[%0d]", i), model_arf[i], arf_out[i]);
        end
    endtask

    // outputs settled mid cycle, acceptance happens on the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (pre_init) begin
                assert (!instr_ready && !result_valid && !idle)
                    else report_failure("instr_ready, result_valid or idle high before init");
            end
            if (result_valid)
                check_result();
            taken = instr_valid && instr_ready;
            if (taken)
                record_instr();
            assert (accepted - results <= N_TAGS)
                else report_failure("more instructions outstanding than rob ids");
        end
    end

    task automatic run_init(input logic [`REG_DATA_WIDTH-1:0] sp);
        int cycles;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        init        = 1'b1;
        init_sp     = sp;
        pre_init    = 1'b0;
        @(posedge clk);
        #1;
        init   = 1'b0;
        cycles = 0;
        // clear walk, one register per cycle
        while (!idle) begin
            assert (!instr_ready && !result_valid)
                else report_failure("instr_ready or result_valid high during clear");
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (cycles == `ARF_N_ENTRIES)
            else report_mismatch("clear cycles", `ARF_N_ENTRIES, cycles);
        // fresh register file, rob ids from 0
        for (int i = 0; i < `ARF_N_ENTRIES; i++)
            model_arf[i] = (i == `SP_INDEX) ? sp : '0;
        for (int i = 0; i < N_TAGS; i++)
            pending[i] = 1'b0;
        model_rob = '0;
        accepted  = 0;
        results   = 0;
        check_arf();
    endtask

    task automatic run_program(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            #1;
            if (instr_valid && taken) begin
                sent++;
                instr_valid = 1'b0;
            end
            if (sent < n) begin
                if (instr_valid) begin
                    // not taken, source may swap the instruction
                    if ($urandom_range(0, 3) == 0)
                        new_random_instr();
                end else if ($urandom_range(0, 2) != 0) begin
                    new_random_instr();
                    instr_valid = 1'b1;
                end
            end
        end
        instr_valid = 1'b0;
    endtask

    task automatic drain_and_check();
        do begin
            @(posedge clk);
            #1;
        end while (!idle);
        assert (results == accepted)
            else report_mismatch("result count", accepted, results);
        check_arf();
    endtask

    initial begin
        void'($urandom(7314));
        rst_n       = 1'b0;
        init        = 1'b0;
        init_sp     = '0;
        instr_valid = 1'b0;
        instr_op    = core_pkg::ALU_ADD;
        instr_rd    = '0;
        instr_rs1   = '0;
        instr_rs2   = '0;
        instr_imm   = '0;
        model_rob   = '0;
        accepted    = 0;
        results     = 0;
        taken       = 1'b0;
        pre_init    = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // offered before init, must not be taken
        new_random_instr();
        instr_valid = 1'b1;
        repeat (10) @(posedge clk);
        for (int p = 0; p < N_PROGRAMS; p++) begin
            run_init(`REG_DATA_WIDTH'($urandom));
            run_program(PROGRAM_LEN);
            drain_and_check();
        end
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Finished with errors");
        $fatal(1);
    end

endmodule
